//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = pwm_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+source
source/apb_pkg.sv
source/pwm_pkg.sv
source/pwm_wave_gen.sv
source/pwm_channel.sv
source/apb_reg_bank.sv
source/pwm_top.sv
tests/pwm_asserts.sv
tests/pwm_tb.sv

//--- source/apb_pkg.sv
// apb request and response struct types
`default_nettype none

package apb_pkg;

    // master side of the bus
    typedef struct packed {
        logic [31:0] paddr;
        logic [31:0] pwdata;
        logic        pwrite;
        logic        psel;
        logic        penable;
    } apb_req_t;

    // slave side
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

//--- source/apb_reg_bank.sv
// apb address decode, period, pulse, config and control registers, read mux
`timescale 1ns/1ps
`default_nettype none
`include "pwm_defs.svh"

module apb_reg_bank
    import apb_pkg::*;
    import pwm_pkg::*;
(
    input  logic                             pclk,
    input  logic                             prst_n,
    input  apb_req_t                         apb_req,
    output apb_rsp_t                         apb_rsp,
    output pwm_setting_t [`PWM_CHANNELS-1:0] setting,
    output logic [`PWM_CHANNELS-1:0]         run,
    output logic [`PWM_CHANNELS-1:0]         invert,
    input  logic [`PWM_CHANNELS-1:0]         chan_en,
    input  logic [`PWM_CHANNELS-1:0]         chan_finish
);

    logic                     wr_en;
    logic                     rd_en;
    logic [`PWM_CHANNELS-1:0] period_hit;
    logic [`PWM_CHANNELS-1:0] pulse_hit;
    logic                     cfg_hit;
    logic                     ctrl_hit;
    logic [31:0]              rdata;

    assign wr_en = apb_req.psel & apb_req.penable & apb_req.pwrite;
    assign rd_en = apb_req.psel & apb_req.penable & ~apb_req.pwrite;

    // --------------------
    // address decode
    // --------------------
    always_comb
    begin
        for (int i = 0; i < `PWM_CHANNELS; i++)
        begin
            period_hit[i] = (apb_req.paddr == (`PWM_BASE_ADDR + `PWM_PERIOD_OFS + 32'(i * 8)));
            pulse_hit[i]  = (apb_req.paddr == (`PWM_BASE_ADDR + `PWM_PULSE_OFS + 32'(i * 8)));
        end
    end

    assign cfg_hit  = (apb_req.paddr == (`PWM_BASE_ADDR + `PWM_CFG_OFS));
    assign ctrl_hit = (apb_req.paddr == (`PWM_BASE_ADDR + `PWM_CTRL_OFS));

    // --------------------
    // registers
    // --------------------
    always_ff @(posedge pclk or negedge prst_n)
    begin
        if (!prst_n)
        begin
            for (int i = 0; i < `PWM_CHANNELS; i++)
            begin
                setting[i].period <= `PWM_PERIOD_RST;
                setting[i].pulse  <= `PWM_PULSE_RST;
            end
        end
        else if (wr_en)
        begin
            for (int i = 0; i < `PWM_CHANNELS; i++)
            begin
                if (period_hit[i])
                    setting[i].period <= apb_req.pwdata;
                if (pulse_hit[i])
                    setting[i].pulse <= apb_req.pwdata;
            end
        end
    end

    // run bits, rising edge starts a channel
    always_ff @(posedge pclk or negedge prst_n)
    begin
        if (!prst_n)
            run <= '0;
        else if (wr_en && ctrl_hit)
            run <= apb_req.pwdata[`PWM_CHANNELS-1:0];
    end

    // polarity, locked while the channel runs
    always_ff @(posedge pclk or negedge prst_n)
    begin
        if (!prst_n)
            invert <= '0;
        else
        begin
            for (int i = 0; i < `PWM_CHANNELS; i++)
            begin
                if (chan_finish[i])
                    invert[i] <= 1'b0;     // self clear on finish
                else if (wr_en && cfg_hit && !chan_en[i])
                    invert[i] <= apb_req.pwdata[i];
            end
        end
    end

    // --------------------
    // read mux
    // --------------------
    always_comb
    begin
        rdata = '0;
        for (int i = 0; i < `PWM_CHANNELS; i++)
        begin
            if (period_hit[i])
                rdata = setting[i].period;
            if (pulse_hit[i])
                rdata = setting[i].pulse;
        end
        if (cfg_hit)
            rdata = {{(32 - `PWM_CHANNELS){1'b0}}, invert};
        if (ctrl_hit)
            rdata = {{(32 - `PWM_CHANNELS){1'b0}}, run};
    end

    // no wait states, no errors
    assign apb_rsp = '{
        prdata:  rd_en ? rdata : 32'h0,
        pready:  1'b1,
        pslverr: 1'b0
    };

endmodule

`default_nettype wire

//--- source/pwm_channel.sv
// one pwm channel: start and finish detect, shadow setting, enable, polarity output
`timescale 1ns/1ps
`default_nettype none

module pwm_channel
    import pwm_pkg::*;
(
    input  logic         pclk,
    input  logic         prst_n,
    input  pwm_setting_t setting,
    input  logic         run,
    input  logic         invert,
    output logic         chan_en,
    output logic         chan_finish,
    output logic         pwm_out
);

    logic         run_d;
    logic         en_d;
    logic         start;
    logic         wrap;
    logic         pulse_end;
    logic         raw_level;
    pwm_setting_t shadow;

    // --------------------
    // edge detect
    // --------------------
    always_ff @(posedge pclk or negedge prst_n)
    begin
        if (!prst_n)
        begin
            run_d <= 1'b0;
            en_d  <= 1'b0;
        end
        else
        begin
            run_d <= run;
            en_d  <= chan_en;
        end
    end

    assign start       = run & ~run_d;
    assign chan_finish = en_d & ~chan_en;    // one cycle after enable falls

    // reload at start and on every wrap
    always_ff @(posedge pclk)
    begin
        if (start || wrap)
            shadow <= setting;
    end

    // stop only at the end of the current pulse
    always_ff @(posedge pclk or negedge prst_n)
    begin
        if (!prst_n)
            chan_en <= 1'b0;
        else if (start)
            chan_en <= 1'b1;
        else if (!run && pulse_end)
            chan_en <= 1'b0;
    end

    pwm_wave_gen u_wave_gen (
        .pclk      (pclk),
        .prst_n    (prst_n),
        .enable    (chan_en),
        .shadow    (shadow),
        .wrap      (wrap),
        .pulse_end (pulse_end),
        .raw_level (raw_level)
    );

    // low whenever idle
    assign pwm_out = chan_en ? (raw_level ^ invert) : 1'b0;

endmodule

`default_nettype wire

//--- source/pwm_defs.svh
// pwm block base address, register offsets, channel count, counter width and reset values
`ifndef PWM_DEFS_SVH
`define PWM_DEFS_SVH

// --------------------
// register map
// --------------------
`define PWM_BASE_ADDR   32'h1A10_2000

// channel 0, each later channel 8 bytes on
`define PWM_PERIOD_OFS  32'h0000_0000
`define PWM_PULSE_OFS   32'h0000_0004

`define PWM_CFG_OFS     32'h0000_0040   // polarity, one bit per channel
`define PWM_CTRL_OFS    32'h0000_0044   // run, one bit per channel

// --------------------
// sizes
// --------------------
`define PWM_CHANNELS    8
`define PWM_CNT_W       32

// --------------------
// reset values
// --------------------
`define PWM_PERIOD_RST  32'hFFFF_FFFF
`define PWM_PULSE_RST   32'h0000_FFFF

`endif

//--- source/pwm_pkg.sv
// pwm counter type and per-channel setting struct
`default_nettype none
`include "pwm_defs.svh"

package pwm_pkg;

    // one counter value, also used for period and pulse
    typedef logic [`PWM_CNT_W-1:0] pwm_cnt_t;

    // --------------------
    // channel setting
    // --------------------
    typedef struct packed {
        pwm_cnt_t period;   // cycles per period
        pwm_cnt_t pulse;    // high cycles per period
    } pwm_setting_t;

endpackage

`default_nettype wire

//--- source/pwm_top.sv
// pwm top level: apb register bank and the channel array
`timescale 1ns/1ps
`default_nettype none
`include "pwm_defs.svh"

module pwm_top
    import apb_pkg::*;
    import pwm_pkg::*;
(
    input  logic                     pclk,
    input  logic                     prst_n,
    input  apb_req_t                 apb_req,
    output apb_rsp_t                 apb_rsp,
    output logic [`PWM_CHANNELS-1:0] pwm_out
);

    pwm_setting_t [`PWM_CHANNELS-1:0] setting;
    logic [`PWM_CHANNELS-1:0]         run;
    logic [`PWM_CHANNELS-1:0]         invert;
    logic [`PWM_CHANNELS-1:0]         chan_en;
    logic [`PWM_CHANNELS-1:0]         chan_finish;

    apb_reg_bank u_reg_bank (
        .pclk        (pclk),
        .prst_n      (prst_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .setting     (setting),
        .run         (run),
        .invert      (invert),
        .chan_en     (chan_en),
        .chan_finish (chan_finish)
    );

    // --------------------
    // channels
    // --------------------
    for (genvar i = 0; i < `PWM_CHANNELS; i++)
    begin : g_chan
        pwm_channel u_chan (
            .pclk        (pclk),
            .prst_n      (prst_n),
            .setting     (setting[i]),
            .run         (run[i]),
            .invert      (invert[i]),
            .chan_en     (chan_en[i]),
            .chan_finish (chan_finish[i]),
            .pwm_out     (pwm_out[i])
        );
    end

endmodule

`default_nettype wire

//--- source/pwm_wave_gen.sv
// period counter with wrap and pulse-end flags, raw waveform register
`timescale 1ns/1ps
`default_nettype none
`include "pwm_defs.svh"

module pwm_wave_gen
    import pwm_pkg::*;
(
    input  logic         pclk,
    input  logic         prst_n,
    input  logic         enable,
    input  pwm_setting_t shadow,
    output logic         wrap,
    output logic         pulse_end,
    output logic         raw_level
);

    pwm_cnt_t cnt;
    pwm_cnt_t last_cnt;
    pwm_cnt_t pulse_cnt;

    assign last_cnt  = shadow.period - `PWM_CNT_W'(1);   // period - 1
    assign pulse_cnt = shadow.pulse - `PWM_CNT_W'(1);

    assign wrap      = enable && (cnt == last_cnt);
    assign pulse_end = enable && (cnt == pulse_cnt);

    // --------------------
    // counter
    // --------------------
    always_ff @(posedge pclk or negedge prst_n)
    begin
        if (!prst_n)
            cnt <= '0;
        else if (!enable)
            cnt <= '0;                  // hold at zero when idle
        else if (wrap)
            cnt <= '0;
        else
            cnt <= cnt + `PWM_CNT_W'(1);
    end

    // high from wrap until pulse end
    always_ff @(posedge pclk or negedge prst_n)
    begin
        if (!prst_n)
            raw_level <= 1'b0;
        else if (!enable)
            raw_level <= 1'b0;
        else if (wrap)
            raw_level <= 1'b1;
        else if (pulse_end)
            raw_level <= 1'b0;
    end

endmodule

`default_nettype wire

//--- tests/pwm_asserts.sv
// concurrent checks on the pwm top level and the bind into pwm_top
`timescale 1ns/1ps
`default_nettype none
`include "pwm_defs.svh"

module pwm_asserts
    import apb_pkg::*;
(
    input logic                     pclk,
    input logic                     prst_n,
    input apb_req_t                 apb_req,
    input apb_rsp_t                 apb_rsp,
    input logic [`PWM_CHANNELS-1:0] chan_en,
    input logic [`PWM_CHANNELS-1:0] pwm_out
);

    int fail_count;   // failures seen so far

    // no wait states, no error responses
    a_rsp_fixed: assert property (@(posedge pclk) disable iff (!prst_n)
        apb_rsp.pready && !apb_rsp.pslverr)
    else
    begin
        fail_count++;
        $error("apb response not ready or flagged a slave error");
    end

    a_idle_low: assert property (@(posedge pclk) disable iff (!prst_n)
        (pwm_out & ~chan_en) == '0)
    else
    begin
        fail_count++;
        $error("pwm output high on an idle channel");
    end

    // read data only during a read access
    a_prdata_zero: assert property (@(posedge pclk) disable iff (!prst_n)
        !(apb_req.psel && apb_req.penable && !apb_req.pwrite) |-> apb_rsp.prdata == '0)
    else
    begin
        fail_count++;
        $error("prdata not zero outside a read access");
    end

endmodule

bind pwm_top pwm_asserts u_asserts (
    .pclk    (pclk),
    .prst_n  (prst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .chan_en (chan_en),
    .pwm_out (pwm_out)
);

`default_nettype wire

//--- tests/pwm_tb.sv
// pwm testbench with clock, reset, apb driver, lfsr, reference model, run-length monitor and tests
`timescale 1ns/1ps
`default_nettype none
`include "pwm_defs.svh"

module pwm_tb
    import apb_pkg::*;
    import pwm_pkg::*;
();

    localparam int          BUS_TIMEOUT = 16;
    localparam logic [31:0] CFG_ADDR    = `PWM_BASE_ADDR + `PWM_CFG_OFS;
    localparam logic [31:0] CTRL_ADDR   = `PWM_BASE_ADDR + `PWM_CTRL_OFS;

    typedef struct packed {
        pwm_cnt_t high;
        pwm_cnt_t low;
    } run_len_t;

    logic                     pclk;
    logic                     prst_n;
    apb_req_t                 apb_req;
    apb_rsp_t                 apb_rsp;
    logic [`PWM_CHANNELS-1:0] pwm_out;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          tests;
    int          failed_tests;
    int          test_err_start;

    // monitor controls set on the rising edge
    logic [2:0]  mon_ch;
    logic        mon_en;
    int          mon_gen;
    run_len_t    mon_exp;
    // monitor state updated on the falling edge
    int          mon_seen_gen;
    int          mon_rises;
    int          mon_checks;
    int          run_errors;
    int          run_checks;
    logic        mon_prev;
    run_len_t    mon_got;

    pwm_top u_dut (
        .pclk    (pclk),
        .prst_n  (prst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .pwm_out (pwm_out)
    );

    initial
    begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    // --------------------
    // helpers
    // --------------------
    function automatic logic next_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (lsb ? 32'h8020_0003 : 32'h0);   // galois step
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], next_bit()};
        return v;
    endfunction

    // steady state high and low run lengths
    function automatic run_len_t expected_runs(input pwm_cnt_t period, input pwm_cnt_t pulse,
                                               input logic pol);
        run_len_t r;
        r.high = pol ? period - pulse : pulse;
        r.low  = pol ? pulse : period - pulse;
        return r;
    endfunction

    function automatic logic [31:0] period_addr(input logic [2:0] ch);
        return `PWM_BASE_ADDR + `PWM_PERIOD_OFS + 32'(ch) * 32'd8;
    endfunction

    function automatic logic [31:0] pulse_addr(input logic [2:0] ch);
        return `PWM_BASE_ADDR + `PWM_PULSE_OFS + 32'(ch) * 32'd8;
    endfunction

    function automatic int total_errors();
        return errors + run_errors;
    endfunction

    task automatic check_reg(input string name, input pwm_cnt_t got, input pwm_cnt_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_runs(input string name, input run_len_t got, input run_len_t exp);
        run_checks++;
        if (got !== exp)
        begin
            run_errors++;
            $display("mismatch at %0t ns: %s high/low got %0d/%0d expected %0d/%0d",
                     $time, name, got.high, got.low, exp.high, exp.low);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout at %0t ns while waiting for %s", $time, what);
    endtask

    // --------------------
    // apb master
    // --------------------
    task automatic apb_access(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(negedge pclk);
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        apb_req.pwrite  = write;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge pclk);
        apb_req.penable = 1'b1;
        waited = 0;
        @(posedge pclk);
        while (!apb_rsp.pready && waited < BUS_TIMEOUT)
        begin
            @(posedge pclk);
            waited++;
        end
        if (!apb_rsp.pready)
            report_timeout("pready");
        rdata = apb_rsp.prdata;   // edge that ends the access
        @(negedge pclk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused_data;
        apb_access(1'b1, addr, data, unused_data);
    endtask

    task automatic read_check(input string name, input logic [31:0] addr, input pwm_cnt_t exp);
        logic [31:0] data;
        apb_access(1'b0, addr, 32'h0, data);
        check_reg(name, data, exp);
    endtask

    // --------------------
    // run length monitor
    // --------------------
    always @(negedge pclk)
    begin
        if (mon_gen != mon_seen_gen)
        begin
            mon_seen_gen = mon_gen;
            mon_prev     = 1'b1;   // no false rise on a high output
            mon_rises    = 0;
            mon_checks   = 0;
        end
        else if (mon_en)
        begin
            if (pwm_out[mon_ch] && !mon_prev)
            begin
                if (mon_rises >= 2)   // first period may be partial
                begin
                    check_runs($sformatf("pwm_out[%0d]", mon_ch), mon_got, mon_exp);
                    mon_checks++;
                end
                mon_rises++;
                mon_got.high = 1;
                mon_got.low  = 0;
            end
            else if (pwm_out[mon_ch])
                mon_got.high++;
            else
                mon_got.low++;
            mon_prev = pwm_out[mon_ch];
        end
    end

    task automatic arm_monitor(input logic [2:0] ch, input run_len_t exp);
        @(posedge pclk);
        mon_ch  = ch;
        mon_exp = exp;
        mon_en  = 1'b1;
        mon_gen++;
    endtask

    task automatic wait_checks(input int n, input int limit);
        int waited;
        waited = 0;
        @(posedge pclk);
        while (mon_checks < n && waited < limit)
        begin
            @(posedge pclk);
            waited++;
        end
        if (mon_checks < n)
            report_timeout($sformatf("%0d measured periods on pwm_out[%0d]", n, mon_ch));
        mon_en = 1'b0;
    endtask

    // output must settle low within P+4 cycles
    task automatic stop_and_check(input logic [2:0] ch, input int period);
        int last_high;
        last_high = -1;
        apb_write(CTRL_ADDR, 32'h0);
        for (int i = 0; i < 2 * period + 8; i++)
        begin
            @(negedge pclk);
            if (pwm_out[ch])
                last_high = i;
        end
        checks++;
        if (last_high >= period + 4)
        begin
            errors++;
            $display("channel %0d output still high %0d cycles after its run bit was cleared",
                     ch, last_high + 1);
        end
    endtask

    task automatic begin_test();
        test_err_start = total_errors();
    endtask

    task automatic end_test(input string name);
        int n;
        n = total_errors() - test_err_start;
        tests++;
        if (n != 0)
            failed_tests++;
        $display("test %0d %s: %s, %0d errors", tests, name, (n == 0) ? "ok" : "fail", n);
    endtask

    // --------------------
    // tests
    // --------------------
    initial
    begin
        logic [2:0]  ch_a;
        logic [2:0]  ch_b;
        pwm_cnt_t    per;
        pwm_cnt_t    pul;
        pwm_cnt_t    per2;
        pwm_cnt_t    per_val [`PWM_CHANNELS];
        pwm_cnt_t    pul_val [`PWM_CHANNELS];
        logic [31:0] val;

        apb_req    = '0;
        prst_n     = 1'b0;
        lfsr_state = 32'hd4aea07d;
        mon_en     = 1'b0;
        mon_ch     = '0;
        mon_exp    = '0;
        repeat (8) @(negedge pclk);
        prst_n = 1'b1;

        begin_test();
        for (int i = 0; i < `PWM_CHANNELS; i++)
        begin
            read_check($sformatf("period[%0d]", i), period_addr(3'(i)), `PWM_PERIOD_RST);
            read_check($sformatf("pulse[%0d]", i), pulse_addr(3'(i)), `PWM_PULSE_RST);
        end
        read_check("cfg", CFG_ADDR, 32'h0);
        read_check("ctrl", CTRL_ADDR, 32'h0);
        read_check("unmapped", `PWM_BASE_ADDR + 32'h80, 32'h0);
        @(negedge pclk);
        check_reg("pwm_out", 32'(pwm_out), 32'h0);
        end_test("reset values");

        begin_test();
        for (int i = 0; i < `PWM_CHANNELS; i++)
        begin
            per_val[i] = rand_bits(32);
            pul_val[i] = rand_bits(32);
            apb_write(period_addr(3'(i)), per_val[i]);
            apb_write(pulse_addr(3'(i)), pul_val[i]);
        end
        for (int i = 0; i < `PWM_CHANNELS; i++)
        begin
            read_check($sformatf("period[%0d]", i), period_addr(3'(i)), per_val[i]);
            read_check($sformatf("pulse[%0d]", i), pulse_addr(3'(i)), pul_val[i]);
        end
        val = rand_bits(32);
        apb_write(CFG_ADDR, val);
        read_check("cfg", CFG_ADDR, val & 32'h0000_00ff);
        apb_write(CFG_ADDR, 32'h0);
        for (int i = 0; i < `PWM_CHANNELS; i++)
        begin
            apb_write(period_addr(3'(i)), 32'd8);   // short period so they stop fast
            apb_write(pulse_addr(3'(i)), 32'd4);
        end
        val = rand_bits(32);
        apb_write(CTRL_ADDR, val);
        read_check("ctrl", CTRL_ADDR, val & 32'h0000_00ff);
        apb_write(CTRL_ADDR, 32'h0);
        repeat (8 + 4) @(negedge pclk);
        end_test("register readback");

        begin_test();
        ch_a = 3'(rand_bits(3));
        per  = 5 + rand_bits(6) % 35;
        pul  = 4 + rand_bits(6) % (per - 4);
        apb_write(period_addr(ch_a), per);
        apb_write(pulse_addr(ch_a), pul);
        arm_monitor(ch_a, expected_runs(per, pul, 1'b0));
        apb_write(CTRL_ADDR, 32'h1 << ch_a);
        wait_checks(3, 5 * per + 20);
        end_test($sformatf("waveform ch%0d P=%0d W=%0d", ch_a, per, pul));

        begin_test();
        per2 = pul + 1 + rand_bits(6) % (39 - pul);
        if (per2 >= per)
            per2++;   // never the running period
        apb_write(period_addr(ch_a), per2);
        arm_monitor(ch_a, expected_runs(per2, pul, 1'b0));
        wait_checks(4, 2 * per + 6 * per2 + 20);
        stop_and_check(ch_a, per2);
        end_test($sformatf("shadowing ch%0d P=%0d->%0d", ch_a, per, per2));

        begin_test();
        ch_b = ch_a + 3'd1 + 3'(rand_bits(2));
        per  = 5 + rand_bits(6) % 36;
        pul  = 4 + rand_bits(6) % (per - 4);
        apb_write(period_addr(ch_b), per);
        apb_write(pulse_addr(ch_b), pul);
        apb_write(CFG_ADDR, 32'h1 << ch_b);
        read_check("cfg before start", CFG_ADDR, 32'h1 << ch_b);
        arm_monitor(ch_b, expected_runs(per, pul, 1'b1));
        apb_write(CTRL_ADDR, 32'h1 << ch_b);
        wait_checks(3, 5 * per + 20);
        apb_write(CFG_ADDR, 32'h0);   // locked while running
        read_check("cfg while running", CFG_ADDR, 32'h1 << ch_b);
        end_test($sformatf("polarity ch%0d P=%0d W=%0d", ch_b, per, pul));

        begin_test();
        stop_and_check(ch_b, per);
        read_check("cfg after stop", CFG_ADDR, 32'h0);
        end_test($sformatf("stop ch%0d", ch_b));

        if (u_dut.u_asserts.fail_count != 0)
        begin
            errors += u_dut.u_asserts.fail_count;
            $display("%0d assertion failures in the bound checker", u_dut.u_asserts.fail_count);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks + run_checks, total_errors());
        if (total_errors() == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
